// File: project.f
+incdir+.
icache_pkg.sv
icache_sram.sv
icache_plru.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module tb_icache -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir

// File: tb_icache.sv
`include "icache_consts.svh"

module tb_icache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [`ICACHE_PADDR_W-1:0] PATTERN = 32'ha5a5_0f0f;

    logic                   clk       = 1'b0;
    logic                   rst       = 1'b1;
    logic                   req_valid = 1'b0;
    icache_pkg::fetch_req_t req       = '0;
    logic                   rsp_ready = 1'b0;
    logic                   req_ready, rsp_valid, ar_valid, ar_ready, r_valid, r_ready;
    icache_pkg::fetch_rsp_t rsp, rsp_prev, exp_rsp;
    icache_pkg::mem_ar_t    ar;
    icache_pkg::mem_r_t     r;
    int                     bursts;
    int                     exp_misses = 0;
    int                     issued     = 0;
    int                     cycles     = 0;
    logic                   busy       = 1'b0;
    bit                     exp_hit    = 1'b0;

    // reference cache keeps per set the last used half and the last used way in each half
    logic [`ICACHE_TAG_W-1:0] model_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic                     model_valid [`ICACHE_SETS][`ICACHE_WAYS] = '{default: 1'b0};
    logic                     mru_half    [`ICACHE_SETS] = '{default: 1'b1};
    logic [1:0]               mru_leaf    [`ICACHE_SETS] = '{default: 2'b11};

    wire        hs_req = req_valid && req_ready;
    wire [35:0] exp_ar = {exp_rsp.addr, `ICACHE_LEN_W'(3)};

    icache_top UUT (
        .clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp, .rsp_ready,
        .ar_valid, .ar, .ar_ready, .r_valid, .r, .r_ready
    );

    tb_mem_model #(.PATTERN(PATTERN)) u_mem (
        .clk, .rst, .ar_valid, .ar, .ar_ready, .r_valid, .r, .r_ready, .bursts
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [159:0] expected,
                                   input logic [159:0] actual);
        $display("[ERROR] %0t %s: expected %0h got %0h", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%0t %s", $time, what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles   <= cycles + 1;
        rsp_prev <= rsp;
        if (hs_req) busy <= 1'b1;
        else if (rsp_valid && rsp_ready) busy <= 1'b0;
        if (cycles > 200 * issued + 100) report_failure("timeout, the cache stopped answering");
    end

    // looks up and fills the reference and returns 1 on a hit
    function automatic bit predict_access(input logic [`ICACHE_PADDR_W-1:0] addr);
        logic [`ICACHE_SET_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [1:0]               way;
        bit                       hit;
        idx = addr[`ICACHE_OFFSET_W +: `ICACHE_SET_W];
        tag = addr[`ICACHE_PADDR_W-1 -: `ICACHE_TAG_W];
        hit = 1'b0;
        way = {~mru_half[idx], ~mru_leaf[idx][~mru_half[idx]]};  // older way in the older half
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        model_valid[idx][way] = 1'b1;
        model_tag[idx][way]   = tag;
        mru_half[idx]         = way[1];
        mru_leaf[idx][way[1]] = way[0];
        return hit;
    endfunction

    function automatic icache_pkg::fetch_rsp_t line_from_memory(
        input logic [`ICACHE_PADDR_W-1:0] addr
    );
        icache_pkg::fetch_rsp_t line_exp;
        line_exp.addr = {addr[`ICACHE_PADDR_W-1:`ICACHE_OFFSET_W], `ICACHE_OFFSET_W'(0)};
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            line_exp.line.word[i] = (line_exp.addr + 32'(4 * i)) ^ PATTERN;
        end
        return line_exp;
    endfunction

    // one fetch with the response held back for stall cycles
    task automatic fetch(input logic [`ICACHE_PADDR_W-1:0] addr, input int stall);
        while (!req_ready) @(negedge clk);
        exp_hit = predict_access(addr);
        exp_rsp = line_from_memory(addr);
        if (!exp_hit) exp_misses++;
        issued++;
        req_valid = 1'b1;
        req.addr  = addr;
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        repeat (stall) @(negedge clk);
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        assert (bursts == exp_misses)
            else report_mismatch("bursts", 160'(exp_misses), 160'(bursts));
    endtask

    hit_latency: assert property (@(posedge clk) disable iff (rst)
        hs_req && exp_hit |-> ##2 rsp_valid)
        else report_mismatch("rsp_valid", 160'(1), 160'($sampled(rsp_valid)));
    lookup_cycle: assert property (@(posedge clk) disable iff (rst) hs_req |=> !rsp_valid)
        else report_mismatch("rsp_valid", 160'(0), 160'($sampled(rsp_valid)));
    miss_burst: assert property (@(posedge clk) disable iff (rst)
        hs_req && !exp_hit |-> ##2 ar_valid)
        else report_mismatch("ar_valid", 160'(1), 160'($sampled(ar_valid)));
    ar_payload: assert property (@(posedge clk) disable iff (rst)
        ar_valid && ar_ready |-> ar == exp_ar)
        else report_mismatch("ar", 160'(exp_ar), 160'($sampled(ar)));
    refill_latency: assert property (@(posedge clk) disable iff (rst)
        r_valid && r_ready && r.last |-> ##2 rsp_valid)
        else report_mismatch("rsp_valid", 160'(1), 160'($sampled(rsp_valid)));
    rsp_payload: assert property (@(posedge clk) disable iff (rst) rsp_valid |-> rsp == exp_rsp)
        else report_mismatch("rsp", $sampled(exp_rsp), $sampled(rsp));
    rsp_held: assert property (@(posedge clk) disable iff (rst) rsp_valid && !rsp_ready |=> rsp_valid)
        else report_mismatch("rsp_valid", 160'(1), 160'($sampled(rsp_valid)));
    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp == rsp_prev)
        else report_mismatch("rsp", $sampled(rsp_prev), $sampled(rsp));
    one_in_flight: assert property (@(posedge clk) disable iff (rst) busy |-> !req_ready)
        else report_mismatch("req_ready", 160'(0), 160'($sampled(req_ready)));

    initial begin
        logic [`ICACHE_PADDR_W-1:0] addr;
        void'($urandom(32'h6ed9));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (req_ready) else report_mismatch("req_ready", 160'(1), 160'(req_ready));
        assert (!rsp_valid) else report_mismatch("rsp_valid", 160'(0), 160'(rsp_valid));
        assert (!ar_valid) else report_mismatch("ar_valid", 160'(0), 160'(ar_valid));
        assert (!r_ready) else report_mismatch("r_ready", 160'(0), 160'(r_ready));
        fetch(32'h0000_1234, 0);  // cold miss
        fetch(32'h0000_1238, 0);  // same line again
        for (int i = 0; i <= 5; i++) begin
            fetch({24'(16 + i % 5), 4'h5, 4'h0}, 0);  // five tags in set 5 then the first one
        end
        fetch(32'h0000_1058, 1 + $urandom_range(6));  // hit with the response held back
        fetch(32'h0000_3000, 1 + $urandom_range(6));  // miss with the response held back
        for (int i = 0; i < 40; i++) begin
            addr = {24'($urandom_range(5)), 4'($urandom_range(1)), 4'($urandom_range(15))};
            fetch(addr, int'($urandom_range(3)));
        end
        @(negedge clk);
        if (bursts == exp_misses) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_mismatch("bursts", 160'(exp_misses), 160'(bursts));
        end
    end

endmodule

// File: tb_mem_model.sv
`include "icache_consts.svh"

module tb_mem_model #(
    parameter logic [`ICACHE_PADDR_W-1:0] PATTERN = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ar_valid,
    input  icache_pkg::mem_ar_t ar,
    output logic                ar_ready,
    output logic                r_valid,
    output icache_pkg::mem_r_t  r,
    input  logic                r_ready,
    output int                  bursts
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`ICACHE_PADDR_W-1:0] addr_q;
    logic [`ICACHE_LEN_W-1:0]   len_q;
    logic [`ICACHE_LEN_W-1:0]   beat;
    logic                       active;
    logic                       r_taken;  // a beat went over at the last rising edge

    initial begin
        ar_ready <= 1'b0;
        r_valid  <= 1'b0;
        r        <= '0;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q  <= '0;
            len_q   <= '0;
            beat    <= '0;
            active  <= 1'b0;
            r_taken <= 1'b0;
            bursts  <= 0;
        end else begin
            r_taken <= r_valid && r_ready;
            if (ar_valid && ar_ready) begin
                addr_q <= ar.addr;
                len_q  <= ar.len;
                beat   <= '0;
                active <= 1'b1;
                bursts <= bursts + 1;
            end
            if (r_valid && r_ready) begin
                beat <= beat + 1'b1;
                if (r.last) active <= 1'b0;
            end
        end
    end

    // random gaps where a raised r_valid holds until its beat is taken
    always @(negedge clk) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            ar_ready <= !active && ($urandom_range(2) != 0);
            if (!r_valid || r_taken) begin
                r_valid <= active && ($urandom_range(2) != 0);
                r.data  <= (addr_q + (32'(beat) << 2)) ^ PATTERN;
                r.last  <= (beat == len_q);
            end
        end
    end

endmodule

// File: icache_top.sv
`include "icache_consts.svh"

module icache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   rsp_ready,
    output logic                   ar_valid,
    output icache_pkg::mem_ar_t    ar,
    input  logic                   ar_ready,
    input  logic                   r_valid,
    input  icache_pkg::mem_r_t     r,
    output logic                   r_ready
);

    logic [`ICACHE_SET_W-1:0]   rd_set;
    logic [`ICACHE_SET_W-1:0]   wr_set;
    icache_pkg::tag_entry_t     tags [`ICACHE_WAYS];
    icache_pkg::line_t          lines [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]    tag_we;
    logic [`ICACHE_WAYS-1:0]    data_we;
    icache_pkg::tag_entry_t     wr_tag;
    icache_pkg::line_t          wr_line;
    logic                       refill_start;
    logic [`ICACHE_PADDR_W-1:0] refill_addr;
    logic                       refill_done;
    icache_pkg::line_t          refill_line;
    logic                       touch;
    logic [`ICACHE_WAY_W-1:0]   touch_way;
    logic [`ICACHE_WAY_W-1:0]   victim;

    icache_ctrl u_ctrl (
        .clk, .rst,
        .req_valid, .req, .req_ready,
        .rsp_valid, .rsp, .rsp_ready,
        .rd_set, .tags, .lines,
        .tag_we, .data_we, .wr_set, .wr_tag, .wr_line,
        .refill_start, .refill_addr, .refill_done, .refill_line,
        .touch, .touch_way, .victim
    );

    icache_sram #(.entry_t(icache_pkg::tag_entry_t), .WAYS(`ICACHE_WAYS)) u_tag_sram (
        .clk, .rst, .rd_set, .rd_data(tags),
        .wr_en(tag_we), .wr_set, .wr_data(wr_tag)
    );

    icache_sram #(.entry_t(icache_pkg::line_t), .WAYS(`ICACHE_WAYS)) u_data_sram (
        .clk, .rst, .rd_set, .rd_data(lines),
        .wr_en(data_we), .wr_set, .wr_data(wr_line)
    );

    // shares the held set with the write port
    icache_plru u_plru (
        .clk, .rst, .set(wr_set), .touch, .touch_way, .victim
    );

    icache_refill u_refill (
        .clk, .rst,
        .start(refill_start), .line_addr(refill_addr),
        .ar_valid, .ar, .ar_ready,
        .r_valid, .r, .r_ready,
        .done(refill_done), .line(refill_line)
    );

endmodule

// File: icache_ctrl.sv
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  icache_pkg::fetch_req_t      req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output icache_pkg::fetch_rsp_t      rsp,
    input  logic                        rsp_ready,
    output logic [`ICACHE_SET_W-1:0]    rd_set,
    input  icache_pkg::tag_entry_t      tags [`ICACHE_WAYS],
    input  icache_pkg::line_t           lines [`ICACHE_WAYS],
    output logic [`ICACHE_WAYS-1:0]     tag_we,
    output logic [`ICACHE_WAYS-1:0]     data_we,
    output logic [`ICACHE_SET_W-1:0]    wr_set,
    output icache_pkg::tag_entry_t      wr_tag,
    output icache_pkg::line_t           wr_line,
    output logic                        refill_start,
    output logic [`ICACHE_PADDR_W-1:0]  refill_addr,
    input  logic                        refill_done,
    input  icache_pkg::line_t           refill_line,
    output logic                        touch,
    output logic [`ICACHE_WAY_W-1:0]    touch_way,
    input  logic [`ICACHE_WAY_W-1:0]    victim
);

    localparam int WAY_W = `ICACHE_WAY_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL,
        ST_RESPOND
    } state_t;

    state_t                     state;
    icache_pkg::fetch_req_t     req_q;
    logic [WAY_W-1:0]           victim_q;
    logic [`ICACHE_TAG_W-1:0]   req_tag;
    logic [`ICACHE_PADDR_W-1:0] line_addr;
    logic                       hit;
    logic [WAY_W-1:0]           hit_way;
    logic                       fill;

    assign req_tag   = req_q.addr[`ICACHE_PADDR_W-1 -: `ICACHE_TAG_W];
    assign line_addr = {req_q.addr[`ICACHE_PADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESPOND);

    // the set follows the incoming address while idle so the read lines up with lookup
    assign wr_set = req_q.addr[`ICACHE_OFFSET_W +: `ICACHE_SET_W];
    assign rd_set = (state == ST_IDLE) ? req.addr[`ICACHE_OFFSET_W +: `ICACHE_SET_W] : wr_set;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (tags[w].valid && tags[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign fill         = (state == ST_REFILL) && refill_done;
    assign tag_we       = fill ? (`ICACHE_WAYS'(1) << victim_q) : '0;
    assign data_we      = tag_we;
    assign wr_tag       = '{valid: 1'b1, tag: req_tag};
    assign wr_line      = refill_line;
    assign refill_start = (state == ST_LOOKUP) && !hit;
    assign refill_addr  = line_addr;
    assign touch        = ((state == ST_LOOKUP) && hit) || fill;
    assign touch_way    = (state == ST_LOOKUP) ? hit_way : victim_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:    if (req_valid) state <= ST_LOOKUP;
                ST_LOOKUP:  state <= hit ? ST_RESPOND : ST_REFILL;
                ST_REFILL:  if (refill_done) state <= ST_RESPOND;
                ST_RESPOND: if (rsp_ready) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) req_q <= req;
        if (state == ST_LOOKUP) begin
            victim_q <= victim;  // way to fill on a miss
            rsp      <= '{line: lines[hit_way], addr: line_addr};
        end
        if (fill) rsp <= '{line: refill_line, addr: line_addr};
    end

endmodule

// File: icache_refill.sv
`include "icache_consts.svh"

module icache_refill (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [`ICACHE_PADDR_W-1:0] line_addr,
    output logic                       ar_valid,
    output icache_pkg::mem_ar_t        ar,
    input  logic                       ar_ready,
    input  logic                       r_valid,
    input  icache_pkg::mem_r_t         r,
    output logic                       r_ready,
    output logic                       done,
    output icache_pkg::line_t          line
);

    localparam int BEAT_W = $clog2(`ICACHE_LINE_WORDS);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA
    } rf_state_t;

    rf_state_t                  state;
    logic [BEAT_W-1:0]          beat;
    logic [`ICACHE_PADDR_W-1:0] addr_q;

    assign ar_valid = (state == RF_ADDR);
    assign r_ready  = (state == RF_DATA);
    assign ar       = '{addr: addr_q, len: `ICACHE_LEN_W'(`ICACHE_LINE_WORDS - 1)};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RF_IDLE;
            beat  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RF_IDLE: if (start) state <= RF_ADDR;
                RF_ADDR: begin
                    if (ar_ready) begin
                        state <= RF_DATA;
                        beat  <= '0;
                    end
                end
                RF_DATA: begin
                    if (r_valid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin  // burst end comes from the bus
                            state <= RF_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == RF_IDLE) addr_q <= line_addr;
        if (state == RF_DATA && r_valid) line.word[beat] <= r.data;
    end

endmodule

// File: icache_plru.sv
`include "icache_consts.svh"

module icache_plru (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ICACHE_SET_W-1:0] set,
    input  logic                     touch,
    input  logic [`ICACHE_WAY_W-1:0] touch_way,
    output logic [`ICACHE_WAY_W-1:0] victim
);

    // bit 0 root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [`ICACHE_SETS-1:0][2:0] tree;
    logic [2:0]                   cur;

    assign cur = tree[set];

    // follow the pointers toward the least recently used way
    always_comb begin
        if (cur[0]) begin
            victim = {1'b1, cur[2]};
        end else begin
            victim = {1'b0, cur[1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tree <= '0;
        end else if (touch) begin
            tree[set][0] <= ~touch_way[1];  // root points to the other half
            if (touch_way[1]) begin
                tree[set][2] <= ~touch_way[0];
            end else begin
                tree[set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

// File: icache_sram.sv
`include "icache_consts.svh"

module icache_sram #(
    parameter type entry_t = logic,
    parameter int  WAYS    = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ICACHE_SET_W-1:0] rd_set,
    output entry_t                   rd_data [WAYS],
    input  logic [WAYS-1:0]          wr_en,
    input  logic [`ICACHE_SET_W-1:0] wr_set,
    input  entry_t                   wr_data
);

    entry_t mem [`ICACHE_SETS][WAYS];

    // cleared on reset so every valid bit starts low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '{default: '0};
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (wr_en[w]) begin
                    mem[wr_set][w] <= wr_data;
                end
            end
        end
    end

    // all ways of the set, one cycle after the index
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_set];
    end

endmodule

// File: icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // fetch request, byte address
    typedef struct packed {
        logic [`ICACHE_PADDR_W-1:0] addr;
    } fetch_req_t;

    // one cache line, word 0 at the lowest address
    typedef struct packed {
        logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0] word;
    } line_t;

    typedef struct packed {
        line_t                      line;
        logic [`ICACHE_PADDR_W-1:0] addr;  // line aligned
    } fetch_rsp_t;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // read address channel payload
    typedef struct packed {
        logic [`ICACHE_PADDR_W-1:0] addr;
        logic [`ICACHE_LEN_W-1:0]   len;
    } mem_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [`ICACHE_WORD_W-1:0] data;
        logic                      last;
    } mem_r_t;

endpackage

// File: icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry
`define ICACHE_WAYS        4
`define ICACHE_WAY_W       2   // way index width
`define ICACHE_SETS        16
`define ICACHE_SET_W       4
`define ICACHE_LINE_WORDS  4   // also the burst length
`define ICACHE_OFFSET_W    4   // byte offset within a line

// address and data widths
`define ICACHE_PADDR_W     32
`define ICACHE_TAG_W       24
`define ICACHE_WORD_W      32

// read channel
`define ICACHE_LEN_W       4   // beat count minus one

`endif
